//--- design/wro_pkg.sv
/*
 * Shared types for the write-ordering shim.
 * Holds the bus widths, the request and response words, the tag
 * operation records passed between heaps and filters, and the address
 * hash. Modules pull these in with a wildcard import in their header.
 */

package wro_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ADDR_BITS  = 32;
    localparam int MDATA_BITS = 16;
    localparam int DATA_BITS  = 32;
    localparam int HASH_BITS  = 9;

    // Widest tag, a heap or filter uses only the low bits it needs
    localparam int TAG_BITS   = 5;

    typedef logic [HASH_BITS-1:0] wro_hash_t;
    typedef logic [TAG_BITS-1:0]  wro_tag_t;

    typedef enum logic
    {
        WRO_READ  = 1'b0,
        WRO_WRITE = 1'b1
    } wro_kind_t;

    // ==============================
    // Stream words
    // ==============================
    typedef struct packed
    {
        wro_kind_t             kind;
        logic [ADDR_BITS-1:0]  addr;
        logic [MDATA_BITS-1:0] mdata;
        logic [DATA_BITS-1:0]  data;
    } wro_req_t;

    typedef struct packed
    {
        wro_kind_t             kind;
        logic [MDATA_BITS-1:0] mdata;
        logic [DATA_BITS-1:0]  data;
    } wro_rsp_t;

    // Release of one tag, used for heap frees and filter removals
    typedef struct packed
    {
        logic     en;
        wro_tag_t tag;
    } wro_tag_op_t;

    // New busy address entered into a filter under its tag
    typedef struct packed
    {
        logic      en;
        wro_tag_t  tag;
        wro_hash_t hash;
    } wro_insert_t;

    // Fold the address into HASH_BITS by XOR of consecutive slices
    function automatic wro_hash_t wro_hash_addr(input logic [ADDR_BITS-1:0] addr);
        wro_hash_t            h;
        logic [ADDR_BITS-1:0] rest;
        h    = '0;
        rest = addr;
        for (int i = 0; i < ADDR_BITS; i += HASH_BITS)
        begin
            h    = h ^ rest[HASH_BITS-1:0];
            rest = rest >> HASH_BITS;
        end
        return h;
    endfunction

endpackage

//--- design/wro_hash_filter.sv
/*
 * Address hash filter for outstanding requests of one kind.
 * Each tag owns one slot holding the hash of its address while the
 * request is in flight. A test compares a hash against all live slots
 * and the answer is registered, so it is seen one cycle after the test.
 */

`timescale 1ns/1ps

module wro_hash_filter
    import wro_pkg::*;
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic        clk,
    input  logic        reset,
    input  wro_hash_t   test_hash,
    input  logic        test_en,
    output logic        conflict,
    input  wro_insert_t insert,
    input  wro_tag_op_t remove
);

    // Only the low tag bits address the table
    localparam int IDX_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

    logic [N_ENTRIES-1:0] entry_valid;
    wro_hash_t            entry_hash [N_ENTRIES];
    logic                 hit;

    // Compare the test hash against every live slot
    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            if (entry_valid[i] && (entry_hash[i] == test_hash))
            begin
                hit = 1'b1;
            end
        end
    end

    // ==============================
    // Slot state and test result
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            entry_valid <= '0;
            conflict    <= 1'b0;
        end
        else
        begin
            // A tag being freed is never the one being inserted
            if (remove.en)
            begin
                entry_valid[remove.tag[IDX_BITS-1:0]] <= 1'b0;
            end
            if (insert.en)
            begin
                entry_valid[insert.tag[IDX_BITS-1:0]] <= 1'b1;
            end
            // A removal in the test cycle is not seen yet, so the answer may be stale-high
            conflict <= test_en && hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (insert.en)
        begin
            entry_hash[insert.tag[IDX_BITS-1:0]] <= insert.hash;
        end
    end

endmodule

//--- design/wro_tag_heap.sv
/*
 * Tag heap for one request kind.
 * Hands out free tags and stores the metadata bits each tag displaced
 * in the outgoing request. The lowest free tag is reserved ahead of
 * time and held until it is allocated, so alloc_tag stays stable while
 * a request waits on the memory side.
 */

`timescale 1ns/1ps

module wro_tag_heap
    import wro_pkg::*;
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  logic [TAG_BITS-1:0] alloc_mdata,
    output wro_tag_t            alloc_tag,
    output logic                not_empty,
    input  wro_tag_t            read_tag,
    output logic [TAG_BITS-1:0] read_mdata,
    input  wro_tag_op_t         free
);

    localparam int IDX_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

    // One bit per tag, set while the tag is free and not reserved
    logic [N_ENTRIES-1:0] free_map;
    logic [N_ENTRIES-1:0] avail;
    logic [IDX_BITS-1:0]  next_tag;
    logic                 next_valid;
    logic [IDX_BITS-1:0]  cand;
    logic                 cand_found;
    logic                 refill;
    logic [TAG_BITS-1:0]  mdata_mem [N_ENTRIES];

    // A tag freed this cycle may be reserved again straight away
    always_comb
    begin
        avail = free_map;
        if (free.en)
        begin
            avail[free.tag[IDX_BITS-1:0]] = 1'b1;
        end
        cand       = '0;
        cand_found = 1'b0;
        // Scan downward so the lowest free tag wins
        for (int i = N_ENTRIES - 1; i >= 0; i--)
        begin
            if (avail[i])
            begin
                cand       = IDX_BITS'(i);
                cand_found = 1'b1;
            end
        end
    end

    assign refill = alloc || !next_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_map   <= '1;
            next_valid <= 1'b0;
            next_tag   <= '0;
        end
        else
        begin
            free_map <= avail;
            if (refill)
            begin
                next_valid <= cand_found;
                next_tag   <= cand;
                if (cand_found)
                begin
                    free_map[cand] <= 1'b0;
                end
            end
        end
    end

    // Displaced metadata is kept under the allocated tag
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            mdata_mem[next_tag] <= alloc_mdata;
        end
    end

    assign alloc_tag  = wro_tag_t'(next_tag);
    assign not_empty  = next_valid;
    assign read_mdata = mdata_mem[read_tag[IDX_BITS-1:0]];

endmodule

//--- design/wro_issue_fsm.sv
/*
 * Held-request controller of the shim.
 * Takes one request at a time, tests its address hash against the
 * outstanding reads and writes, and issues it toward memory with a tag
 * in the low metadata bits. On issue the tag is allocated from the heap
 * of the request's kind and the hash enters that kind's filter.
 */

`timescale 1ns/1ps

module wro_issue_fsm
    import wro_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    output logic                req_ready,
    input  wro_req_t            req,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output wro_req_t            mem_req,
    output wro_hash_t           test_hash,
    output logic                rd_test_en,
    output logic                wr_test_en,
    input  logic                rd_conflict,
    input  logic                wr_conflict,
    output wro_insert_t         rd_insert,
    output wro_insert_t         wr_insert,
    output logic                rd_alloc,
    output logic                wr_alloc,
    output logic [TAG_BITS-1:0] alloc_mdata,
    input  wro_tag_t            rd_alloc_tag,
    input  wro_tag_t            wr_alloc_tag,
    input  logic                rd_not_empty,
    input  logic                wr_not_empty
);

    typedef enum logic [1:0]
    {
        IDLE,
        TEST,
        ISSUE
    } state_t;

    state_t    state;
    wro_req_t  held;
    wro_hash_t held_hash;
    logic      is_write;
    logic      blocked;
    logic      fire;
    wro_tag_t  tag;

    // ==============================
    // Decisions on the held request
    // ==============================
    assign is_write  = (held.kind == WRO_WRITE);
    assign req_ready = (state == IDLE);

    // Writes must clear both filters, reads only the write filter
    assign test_hash  = held_hash;
    assign wr_test_en = (state == TEST);
    assign rd_test_en = (state == TEST) && is_write;

    // The conflict flags are only meaningful in the first ISSUE cycle.
    // After that they read low, which is safe because only this block
    // inserts into the filters and the reserved heap tag cannot vanish
    assign blocked = is_write ? (wr_conflict || rd_conflict || !wr_not_empty)
                              : (wr_conflict || !rd_not_empty);

    assign mem_req_valid = (state == ISSUE) && !blocked;
    assign fire          = mem_req_valid && mem_req_ready;
    assign tag           = is_write ? wr_alloc_tag : rd_alloc_tag;

    // Swap the tag into the low metadata bits and save what it displaced
    always_comb
    begin
        mem_req                   = held;
        mem_req.mdata[TAG_BITS-1:0] = tag;
    end

    assign alloc_mdata = held.mdata[TAG_BITS-1:0];
    assign rd_alloc    = fire && !is_write;
    assign wr_alloc    = fire && is_write;

    assign rd_insert = '{en: rd_alloc, tag: rd_alloc_tag, hash: held_hash};
    assign wr_insert = '{en: wr_alloc, tag: wr_alloc_tag, hash: held_hash};

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req_valid)
                    begin
                        state <= TEST;
                    end
                end
                // Filter answer registers at this edge
                TEST:
                begin
                    state <= ISSUE;
                end
                ISSUE:
                begin
                    // A blocked request goes back for a fresh test
                    if (blocked)
                    begin
                        state <= TEST;
                    end
                    else if (fire)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Capture the request and its hash on accept
    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
        begin
            held      <= req;
            held_hash <= wro_hash_addr(req.addr);
        end
    end

endmodule

//--- design/wro_rsp_path.sv
/*
 * Response path of the shim.
 * Splits each memory response by kind into a tag release for that
 * kind's heap and filter, reads back the metadata bits the tag
 * displaced, and registers the restored response one cycle later.
 */

`timescale 1ns/1ps

module wro_rsp_path
    import wro_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_rsp_valid,
    input  wro_rsp_t            mem_rsp,
    output wro_tag_op_t         rd_release,
    output wro_tag_op_t         wr_release,
    output wro_tag_t            rd_read_tag,
    output wro_tag_t            wr_read_tag,
    input  logic [TAG_BITS-1:0] rd_mdata,
    input  logic [TAG_BITS-1:0] wr_mdata,
    output logic                rsp_valid,
    output wro_rsp_t            rsp
);

    wro_tag_t rsp_tag;
    logic     is_rd;
    logic     is_wr;

    assign rsp_tag = mem_rsp.mdata[TAG_BITS-1:0];
    assign is_rd   = mem_rsp_valid && (mem_rsp.kind == WRO_READ);
    assign is_wr   = mem_rsp_valid && (mem_rsp.kind == WRO_WRITE);

    // Idle read ports sit on tag 0 so they never index past a short heap
    assign rd_read_tag = is_rd ? rsp_tag : '0;
    assign wr_read_tag = is_wr ? rsp_tag : '0;

    // The release lands at the same edge that captures the response
    assign rd_release = '{en: is_rd, tag: rsp_tag};
    assign wr_release = '{en: is_wr, tag: rsp_tag};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= mem_rsp_valid;
        end
    end

    // Restore the original low metadata bits from the heap
    always_ff @(posedge clk)
    begin
        rsp <= mem_rsp;
        rsp.mdata[TAG_BITS-1:0] <= (mem_rsp.kind == WRO_WRITE) ? wr_mdata : rd_mdata;
    end

endmodule

//--- design/wro_top.sv
/*
 * Top level of the write-ordering shim.
 * Requests enter on req, leave toward memory on mem_req with a tag in
 * the low metadata bits, and come back on mem_rsp in any order. Writes
 * wait for older same-hash reads and writes, reads for older writes.
 * RD_TAGS and WR_TAGS set the number of reads and writes in flight.
 */

`timescale 1ns/1ps

module wro_top
    import wro_pkg::*;
#(
    parameter int RD_TAGS = 24,
    parameter int WR_TAGS = 12
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    output logic     req_ready,
    input  wro_req_t req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output wro_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  wro_rsp_t mem_rsp,
    output logic     rsp_valid,
    output wro_rsp_t rsp
);

    // ==============================
    // Filter and heap connections
    // ==============================
    wro_hash_t           test_hash;
    logic                rd_test_en;
    logic                wr_test_en;
    logic                rd_conflict;
    logic                wr_conflict;
    wro_insert_t         rd_insert;
    wro_insert_t         wr_insert;
    logic                rd_alloc;
    logic                wr_alloc;
    logic [TAG_BITS-1:0] alloc_mdata;
    wro_tag_t            rd_alloc_tag;
    wro_tag_t            wr_alloc_tag;
    logic                rd_not_empty;
    logic                wr_not_empty;
    wro_tag_op_t         rd_release;
    wro_tag_op_t         wr_release;
    wro_tag_t            rd_read_tag;
    wro_tag_t            wr_read_tag;
    logic [TAG_BITS-1:0] rd_mdata;
    logic [TAG_BITS-1:0] wr_mdata;

    wro_issue_fsm issue_i (
        .clk, .reset,
        .req_valid, .req_ready, .req,
        .mem_req_valid, .mem_req_ready, .mem_req,
        .test_hash, .rd_test_en, .wr_test_en,
        .rd_conflict, .wr_conflict,
        .rd_insert, .wr_insert,
        .rd_alloc, .wr_alloc, .alloc_mdata,
        .rd_alloc_tag, .wr_alloc_tag,
        .rd_not_empty, .wr_not_empty
    );

    // Outstanding reads, tested only by held writes
    wro_hash_filter #(.N_ENTRIES(RD_TAGS)) rd_filter_i (
        .clk, .reset,
        .test_hash, .test_en(rd_test_en), .conflict(rd_conflict),
        .insert(rd_insert), .remove(rd_release)
    );

    // Outstanding writes, tested by every held request
    wro_hash_filter #(.N_ENTRIES(WR_TAGS)) wr_filter_i (
        .clk, .reset,
        .test_hash, .test_en(wr_test_en), .conflict(wr_conflict),
        .insert(wr_insert), .remove(wr_release)
    );

    wro_tag_heap #(.N_ENTRIES(RD_TAGS)) rd_heap_i (
        .clk, .reset,
        .alloc(rd_alloc), .alloc_mdata, .alloc_tag(rd_alloc_tag),
        .not_empty(rd_not_empty),
        .read_tag(rd_read_tag), .read_mdata(rd_mdata),
        .free(rd_release)
    );

    wro_tag_heap #(.N_ENTRIES(WR_TAGS)) wr_heap_i (
        .clk, .reset,
        .alloc(wr_alloc), .alloc_mdata, .alloc_tag(wr_alloc_tag),
        .not_empty(wr_not_empty),
        .read_tag(wr_read_tag), .read_mdata(wr_mdata),
        .free(wr_release)
    );

    wro_rsp_path rsp_i (
        .clk, .reset,
        .mem_rsp_valid, .mem_rsp,
        .rd_release, .wr_release,
        .rd_read_tag, .wr_read_tag,
        .rd_mdata, .wr_mdata,
        .rsp_valid, .rsp
    );

endmodule

//--- verif/wro_tb.sv
/*
 * Self-checking testbench for the write-ordering shim.
 * Sends random reads and writes over a small address pool, plays the
 * memory side with out-of-order answers and one long silent stretch,
 * and checks order, tags, conflicts and restored responses against a
 * model kept here. Run it as the top module next to wro_top.
 */

`timescale 1ns/1ps

module wro_tb
    import wro_pkg::*;
();

    localparam int RD_TAGS     = 24;
    localparam int WR_TAGS     = 12;
    localparam int N_REQ       = 400;
    localparam int POOL        = 8;
    localparam int CLK_PERIOD  = 4;
    localparam int HOLD_AFTER  = 120;
    localparam int HOLD_CYCLES = 200;

    // One request as the model sees it, tag and data filled in on issue
    typedef struct
    {
        wro_kind_t             kind;
        int                    idx;
        logic [MDATA_BITS-1:0] mdata;
        logic [DATA_BITS-1:0]  data;
        wro_tag_t              tag;
    } entry_t;

    logic     clk;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    wro_req_t req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    wro_req_t mem_req;
    logic     mem_rsp_valid;
    wro_rsp_t mem_rsp;
    logic     rsp_valid;
    wro_rsp_t rsp;

    integer               seed;
    logic [ADDR_BITS-1:0] pool_addr [POOL];
    logic [DATA_BITS-1:0] mem_data [POOL];
    entry_t               acc_q [$];
    entry_t               out_q [$];
    entry_t               cur;
    entry_t               exp_rsp;
    bit                   have_req;
    bit                   exp_valid;
    bit                   last_stall;
    bit                   holding;
    wro_req_t             last_mem_req;
    int                   sent;
    int                   issued;
    int                   rsp_count;
    int                   answer_idx;
    int                   gap;
    int                   hold_count;
    int                   peak_rd;

    wro_top #(.RD_TAGS(RD_TAGS), .WR_TAGS(WR_TAGS)) dut_i (
        .clk, .reset,
        .req_valid, .req_ready, .req,
        .mem_req_valid, .mem_req_ready, .mem_req,
        .mem_rsp_valid, .mem_rsp,
        .rsp_valid, .rsp
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Failure reporting
    // ==============================
    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_failure(input string why);
        $display("ERROR at %0t: %s", $time, why);
        stop_run();
    endtask

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act)
        begin
            $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
            stop_run();
        end
    endtask

    // ==============================
    // Stimulus and memory side
    // ==============================
    task automatic drive_inputs();
        int k;
        // The silent stretch opens with nothing in flight and a read next in line
        if (!holding && hold_count == 0 && issued >= HOLD_AFTER && have_req &&
            cur.kind == WRO_READ && acc_q.size() == 0 && out_q.size() == 0)
        begin
            holding = 1'b1;
        end
        if (!have_req && sent < N_REQ)
        begin
            // Only reads while memory is silent, so they can use up every read tag
            cur.kind  = (($random(seed) & 1) && !holding) ? WRO_WRITE : WRO_READ;
            cur.idx   = $unsigned($random(seed)) % POOL;
            cur.mdata = 16'($random(seed));
            cur.data  = $random(seed);
            cur.tag   = '0;
            have_req  = 1'b1;
        end
        req_valid = have_req && (($random(seed) & 3) != 0);
        req       = '{kind: cur.kind, addr: pool_addr[cur.idx], mdata: cur.mdata, data: cur.data};
        mem_req_ready = ($random(seed) & 3) != 0;

        // Memory stays silent for a stretch once enough requests went out
        mem_rsp_valid = 1'b0;
        answer_idx    = -1;
        if (holding)
        begin
            hold_count++;
            if (hold_count == HOLD_CYCLES)
            begin
                holding = 1'b0;
                check("peak outstanding reads", 128'(RD_TAGS), 128'(peak_rd));
            end
        end
        else if (gap > 0)
        begin
            gap--;
        end
        else if (out_q.size() > 0)
        begin
            // Any outstanding entry may be answered, so order is random
            k             = $unsigned($random(seed)) % out_q.size();
            answer_idx    = k;
            mem_rsp_valid = 1'b1;
            mem_rsp.kind  = out_q[k].kind;
            mem_rsp.mdata = {out_q[k].mdata[MDATA_BITS-1:TAG_BITS], out_q[k].tag};
            // A read returns whatever memory holds at answer time
            mem_rsp.data  = (out_q[k].kind == WRO_WRITE) ? out_q[k].data : mem_data[out_q[k].idx];
            gap           = $unsigned($random(seed)) % 4;
        end
    endtask

    // ==============================
    // Output checks at the falling edge
    // ==============================
    task automatic sample_outputs();
        entry_t e;
        int     lim;
        int     n_rd;
        int     n_wr;
        // The restored response trails its memory response by one cycle
        check("rsp_valid", 128'(exp_valid), 128'(rsp_valid));
        if (exp_valid)
        begin
            check("rsp.kind", 128'(exp_rsp.kind), 128'(rsp.kind));
            check("rsp.mdata", 128'(exp_rsp.mdata), 128'(rsp.mdata));
            check("rsp.data", 128'(exp_rsp.data), 128'(rsp.data));
            rsp_count++;
        end
        exp_valid = 1'b0;

        // A stalled memory request must not move
        if (last_stall)
        begin
            check("mem_req_valid", 128'(1), 128'(mem_req_valid));
            check("mem_req", 128'(last_mem_req), 128'(mem_req));
        end
        last_stall   = mem_req_valid && !mem_req_ready;
        last_mem_req = mem_req;

        if (mem_req_valid && mem_req_ready)
        begin
            if (acc_q.size() == 0)
            begin
                report_failure("memory request issued with no accepted request waiting");
            end
            else
            begin
                e = acc_q.pop_front();
                check("mem_req.kind", 128'(e.kind), 128'(mem_req.kind));
                check("mem_req.addr", 128'(pool_addr[e.idx]), 128'(mem_req.addr));
                check("mem_req.data", 128'(e.data), 128'(mem_req.data));
                check("mem_req.mdata high bits", 128'(e.mdata[MDATA_BITS-1:TAG_BITS]),
                      128'(mem_req.mdata[MDATA_BITS-1:TAG_BITS]));
                e.tag = mem_req.mdata[TAG_BITS-1:0];
                lim   = (e.kind == WRO_WRITE) ? WR_TAGS : RD_TAGS;
                check("mem_req tag below limit", 128'(1), 128'(int'(e.tag) < lim));
                foreach (out_q[i])
                begin
                    if (out_q[i].kind == e.kind && out_q[i].tag == e.tag)
                    begin
                        report_failure($sformatf("tag %0d issued while still in use", e.tag));
                    end
                    if (out_q[i].idx == e.idx &&
                        (out_q[i].kind == WRO_WRITE || e.kind == WRO_WRITE))
                    begin
                        report_failure("request issued over an outstanding conflict on its address");
                    end
                end
                // With no write in flight to this address, memory cannot change before the answer
                if (e.kind == WRO_READ)
                begin
                    e.data = mem_data[e.idx];
                end
                out_q.push_back(e);
                issued++;
            end
        end

        if (req_valid && req_ready)
        begin
            acc_q.push_back(cur);
            have_req = 1'b0;
            sent++;
        end

        // Memory response lands at the coming edge, writes update memory then
        if (mem_rsp_valid)
        begin
            e = out_q[answer_idx];
            if (e.kind == WRO_WRITE)
            begin
                mem_data[e.idx] = e.data;
            end
            exp_rsp   = e;
            exp_valid = 1'b1;
            out_q.delete(answer_idx);
        end

        n_rd = 0;
        n_wr = 0;
        foreach (out_q[i])
        begin
            if (out_q[i].kind == WRO_WRITE)
                n_wr++;
            else
                n_rd++;
        end
        check("outstanding reads within limit", 128'(1), 128'(n_rd <= RD_TAGS));
        check("outstanding writes within limit", 128'(1), 128'(n_wr <= WR_TAGS));
        // The silent stretch must drive the read heap all the way to empty
        if (holding && n_rd > peak_rd)
        begin
            peak_rd = n_rd;
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            sample_outputs();
        end
    end

    // Watchdog sized for 80 cycles per request
    initial
    begin
        #(N_REQ * 80 * CLK_PERIOD);
        report_failure("timeout, not all requests completed");
    end

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin
        seed          = 32'h49e3;
        clk           = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        have_req      = 1'b0;
        exp_valid     = 1'b0;
        last_stall    = 1'b0;
        holding       = 1'b0;
        last_mem_req  = '0;
        sent          = 0;
        issued        = 0;
        rsp_count     = 0;
        answer_idx    = -1;
        gap           = 0;
        hold_count    = 0;
        peak_rd       = 0;
        for (int i = 0; i < POOL; i++)
        begin
            pool_addr[i] = $random(seed);
            mem_data[i]  = pool_addr[i] ^ {pool_addr[i][15:0], pool_addr[i][31:16]} ^ 32'h3c5a96e1;
        end

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check("req_ready after reset", 128'(1), 128'(req_ready));
        check("mem_req_valid after reset", 128'(0), 128'(mem_req_valid));
        check("rsp_valid after reset", 128'(0), 128'(rsp_valid));

        while (rsp_count < N_REQ)
        begin
            @(posedge clk);
            #1;
            drive_inputs();
        end

        // Let the last response drain, then the DUT must sit idle
        req_valid     = 1'b0;
        mem_rsp_valid = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check("req_ready at end", 128'(1), 128'(req_ready));
        check("mem_req_valid at end", 128'(0), 128'(mem_req_valid));
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
design/wro_pkg.sv
design/wro_hash_filter.sv
design/wro_tag_heap.sv
design/wro_issue_fsm.sv
design/wro_rsp_path.sv
design/wro_top.sv
verif/wro_tb.sv

//--- run.sh
#!/bin/sh
# Compile the shim and its testbench with Verilator, run, and judge by the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f vlog.f --top-module wro_tb -Mdir "$BUILD_DIR" -o wro_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/wro_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
    if [ $sim_status -ne 0 ]; then
        echo "Simulation exited with status $sim_status"
        exit 1
    fi
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see $LOG"
exit 1
